// ==== compile.f ====
adc_ctrl_pkg.sv
apb_regs.sv
board_outputs.sv
extclk_monitor.sv
adc_ctrl_top.sv
tb_clk_gen.sv
adc_ctrl_chk.sv
tb_adc_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_adc_ctrl -f compile.f -o sim_adc_ctrl
./obj_dir/sim_adc_ctrl +verilator+error+limit+1000 | tee sim.log

if grep -q "Finished with no errors" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// ==== tb_adc_ctrl.sv ====
module tb_adc_ctrl;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMER_BITS     = 10;
   localparam int WINDOW         = 2 ** (TIMER_BITS - 3);  // gate period in cycles
   localparam int TIMEOUT_CYCLES = 6000;

   logic        clk_usb;
   logic        reset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        ext_clk;
   logic        trigger;
   logic        capture_active;
   logic        led_armed;
   logic        led_capture;
   logic        amp_gain;
   logic [31:0] rdata;
   logic [7:0]  gain_val;
   int unsigned half_d    = 4;  // ext_clk half period in cycles
   int unsigned cycle_cnt = 0;
   int unsigned rd_errors = 0;
   int          mode;

   tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_clk_gen (.clk_o(clk_usb), .reset_o(reset));

   adc_ctrl_top #(
      .pTIMER_BITS (TIMER_BITS)
   ) u_dut (
      .clk_usb          (clk_usb),
      .reset            (reset),
      .psel_i           (psel),
      .penable_i        (penable),
      .pwrite_i         (pwrite),
      .paddr_i          (paddr),
      .pwdata_i         (pwdata),
      .ext_clk_i        (ext_clk),
      .trigger_i        (trigger),
      .capture_active_i (capture_active),
      .prdata_o         (prdata),
      .pready_o         (pready),
      .pslverr_o        (pslverr),
      .led_armed_o      (led_armed),
      .led_capture_o    (led_capture),
      .amp_gain_o       (amp_gain)
   );

   // one APB transfer, setup then access phase, read data taken mid-access
   task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rd);
      @(posedge clk_usb);
      #1;
      psel   = 1'b1;
      pwrite = write;
      paddr  = addr;
      pwdata = wdata;
      @(posedge clk_usb);
      #1;
      penable = 1'b1;
      @(negedge clk_usb);
      rd = prdata;
      @(posedge clk_usb);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic check_range(input string name, input logic [31:0] got,
                              input int unsigned lo, input int unsigned hi);
      if (got < lo || got > hi) begin
         rd_errors++;
         $display("[ERROR] %0t %s: expected %0d..%0d, got %0d", $time, name, lo, hi, got);
      end
   endtask

   initial begin
      ext_clk = 1'b0;
      forever begin
         repeat (half_d) @(posedge clk_usb);
         #1;
         ext_clk = ~ext_clk;
      end
   end

   always @(posedge clk_usb) begin
      cycle_cnt++;
      if (cycle_cnt > TIMEOUT_CYCLES) begin
         $display("run stopped after %0d cycles, the tests did not complete", TIMEOUT_CYCLES);
         $display("Finished with errors");
         $finish;
      end
   end

   initial begin
      psel           = 1'b0;
      penable        = 1'b0;
      pwrite         = 1'b0;
      paddr          = '0;
      pwdata         = '0;
      trigger        = 1'b0;
      capture_active = 1'b0;
      rdata          = $urandom(32'hcbd67d56);
      gain_val       = 8'($urandom_range(1, 255));
      wait (reset == 1'b0);

      // readback of the writable registers
      apb_xfer(1'b1, adc_ctrl_pkg::REG_CTRL, $urandom(), rdata);
      apb_xfer(1'b0, adc_ctrl_pkg::REG_CTRL, '0, rdata);
      apb_xfer(1'b1, adc_ctrl_pkg::REG_GAIN, {24'b0, gain_val}, rdata);
      apb_xfer(1'b0, adc_ctrl_pkg::REG_GAIN, '0, rdata);
      apb_xfer(1'b1, adc_ctrl_pkg::REG_LIMIT, $urandom() | 32'h8000_0000, rdata);  // flag stays off
      apb_xfer(1'b0, adc_ctrl_pkg::REG_LIMIT, '0, rdata);

      // slave errors, then the registers must read back unchanged
      apb_xfer(1'b0, 8'h14, '0, rdata);
      apb_xfer(1'b1, 8'h20, $urandom(), rdata);
      apb_xfer(1'b1, adc_ctrl_pkg::REG_FREQ, $urandom(), rdata);
      apb_xfer(1'b1, adc_ctrl_pkg::REG_STATUS, $urandom(), rdata);
      apb_xfer(1'b0, adc_ctrl_pkg::REG_GAIN, '0, rdata);
      apb_xfer(1'b0, adc_ctrl_pkg::REG_LIMIT, '0, rdata);

      // armed, normal LEDs, several pwm windows
      apb_xfer(1'b1, adc_ctrl_pkg::REG_CTRL, 32'h8, rdata);
      repeat (800) begin
         @(posedge clk_usb);
         #1;
         capture_active = 1'($urandom_range(0, 1));
      end

      // frequency measurement with D = 8
      apb_xfer(1'b0, adc_ctrl_pkg::REG_FREQ, '0, rdata);
      check_range("REG_FREQ", rdata, WINDOW / 8 - 1, WINDOW / 8 + 1);
      apb_xfer(1'b1, adc_ctrl_pkg::REG_LIMIT, 32'd2, rdata);
      repeat (2 * WINDOW) @(posedge clk_usb);
      apb_xfer(1'b0, adc_ctrl_pkg::REG_STATUS, '0, rdata);
      check_range("REG_STATUS[0]", 32'(rdata[0]), 0, 0);

      half_d = 2;  // D = 4, count doubles
      repeat (2 * WINDOW + 8) @(posedge clk_usb);
      apb_xfer(1'b0, adc_ctrl_pkg::REG_STATUS, '0, rdata);
      check_range("REG_STATUS[0]", 32'(rdata[0]), 1, 1);
      for (mode = 0; mode < 4; mode++) begin
         apb_xfer(1'b1, adc_ctrl_pkg::REG_CTRL, mode, rdata);
         repeat (WINDOW) @(posedge clk_usb);
      end
      apb_xfer(1'b0, adc_ctrl_pkg::REG_FREQ, '0, rdata);
      check_range("REG_FREQ", rdata, WINDOW / 4 - 1, WINDOW / 4 + 1);

      // monitor_disable clears the flag, trigger shows in status
      trigger = 1'b1;
      apb_xfer(1'b1, adc_ctrl_pkg::REG_CTRL, 32'h4, rdata);
      apb_xfer(1'b0, adc_ctrl_pkg::REG_STATUS, '0, rdata);
      check_range("REG_STATUS[0]", 32'(rdata[0]), 0, 0);
      check_range("REG_STATUS[1]", 32'(rdata[1]), 1, 1);
      apb_xfer(1'b1, adc_ctrl_pkg::REG_CTRL, 32'h0, rdata);
      repeat (WINDOW) @(posedge clk_usb);

      $display("assertion failures: %0d, read mismatches: %0d", u_dut.u_chk.fail_cnt, rd_errors);
      if (u_dut.u_chk.fail_cnt == 0 && rd_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== adc_ctrl_chk.sv ====
module adc_ctrl_chk (
   input logic                            clk_usb,
   input logic                            reset,
   input logic                            psel_i,
   input logic                            penable_i,
   input logic                            pwrite_i,
   input logic [adc_ctrl_pkg::ADDR_W-1:0] paddr_i,
   input logic [adc_ctrl_pkg::DATA_W-1:0] pwdata_i,
   input logic [adc_ctrl_pkg::DATA_W-1:0] prdata_i,
   input logic                            pready_i,
   input logic                            pslverr_i,
   input logic                            capture_active_i,
   input logic                            led_armed_i,
   input logic                            led_capture_i,
   input logic                            amp_gain_i,
   input logic                            change_i
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [adc_ctrl_pkg::CTRL_W-1:0] ctrl_sh;  // shadow copies of the writable registers
   logic [adc_ctrl_pkg::GAIN_W-1:0] gain_sh;
   logic [adc_ctrl_pkg::FREQ_W-1:0] limit_sh;
   logic [adc_ctrl_pkg::DATA_W-1:0] exp_rdata;
   logic                            access;
   logic                            rw_addr;
   logic                            ro_addr;
   logic                            exp_err;
   logic [7:0]                      win_cyc;   // position in the 256-cycle pwm window
   logic [8:0]                      win_hi;
   logic [8:0]                      win_sum;
   logic [9:0]                      gain_age;  // cycles since the last gain write
   int unsigned                     fail_cnt = 0;

   assign access  = psel_i & penable_i;
   assign rw_addr = (paddr_i == adc_ctrl_pkg::REG_CTRL) || (paddr_i == adc_ctrl_pkg::REG_GAIN) ||
                    (paddr_i == adc_ctrl_pkg::REG_LIMIT);
   assign ro_addr = (paddr_i == adc_ctrl_pkg::REG_FREQ) || (paddr_i == adc_ctrl_pkg::REG_STATUS);
   assign exp_err = ~(rw_addr | ro_addr) | (pwrite_i & ro_addr);
   assign win_sum = win_hi + {8'b0, amp_gain_i};

   always_comb begin
      exp_rdata = '0;
      case (paddr_i)
         adc_ctrl_pkg::REG_CTRL: exp_rdata[adc_ctrl_pkg::CTRL_W-1:0] = ctrl_sh;
         adc_ctrl_pkg::REG_GAIN: exp_rdata[adc_ctrl_pkg::GAIN_W-1:0] = gain_sh;
         default:                exp_rdata = limit_sh;
      endcase
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ctrl_sh  <= '0;
         gain_sh  <= '0;
         limit_sh <= '0;
      end else if (access && pwrite_i) begin
         if (paddr_i == adc_ctrl_pkg::REG_CTRL) ctrl_sh <= pwdata_i[adc_ctrl_pkg::CTRL_W-1:0];
         if (paddr_i == adc_ctrl_pkg::REG_GAIN) gain_sh <= pwdata_i[adc_ctrl_pkg::GAIN_W-1:0];
         if (paddr_i == adc_ctrl_pkg::REG_LIMIT) limit_sh <= pwdata_i;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         win_cyc  <= '0;
         win_hi   <= '0;
         gain_age <= '0;
      end else begin
         win_cyc <= win_cyc + 8'd1;
         win_hi  <= (win_cyc == 8'hff) ? '0 : win_sum;
         if (access && pwrite_i && paddr_i == adc_ctrl_pkg::REG_GAIN) gain_age <= '0;
         else if (gain_age != '1) gain_age <= gain_age + 10'd1;
      end
   end

   a_ready: assert property (@(posedge clk_usb) pready_i)
      else begin
         $error("pready_o went low");
         fail_cnt = fail_cnt + 1;
      end

   a_slverr: assert property (@(posedge clk_usb) disable iff (reset)
      access |-> (pslverr_i == exp_err))
      else begin
         $error("[ERROR] %0t pslverr_o: got %0b, expected %0b", $time,
                $sampled(pslverr_i), $sampled(exp_err));
         fail_cnt = fail_cnt + 1;
      end

   a_readback: assert property (@(posedge clk_usb) disable iff (reset)
      (access && !pwrite_i && rw_addr) |-> (prdata_i == exp_rdata))
      else begin
         $error("[ERROR] %0t prdata_o: got %h, expected %h", $time,
                $sampled(prdata_i), $sampled(exp_rdata));
         fail_cnt = fail_cnt + 1;
      end

   // window only counts once the gain has been stable for a full window
   a_pwm: assert property (@(posedge clk_usb) disable iff (reset)
      ((win_cyc == 8'hff) && (gain_age > 10'd260)) |-> (win_sum == {1'b0, gain_sh}))
      else begin
         $error("[ERROR] %0t amp_gain_o high cycles: got %0d, expected %0d", $time,
                $sampled(win_sum), $sampled(gain_sh));
         fail_cnt = fail_cnt + 1;
      end

   a_led_normal: assert property (@(posedge clk_usb) disable iff (reset)
      (ctrl_sh[adc_ctrl_pkg::CTRL_LED_LSB +: adc_ctrl_pkg::LED_SEL_W] == adc_ctrl_pkg::LED_NORMAL &&
       !change_i) |-> (led_armed_i == ctrl_sh[adc_ctrl_pkg::CTRL_ARM_BIT] &&
                       led_capture_i == capture_active_i))
      else begin
         $error("[ERROR] %0t led_armed_o/led_capture_o: got %b/%b, expected %b/%b", $time,
                $sampled(led_armed_i), $sampled(led_capture_i),
                $sampled(ctrl_sh[adc_ctrl_pkg::CTRL_ARM_BIT]), $sampled(capture_active_i));
         fail_cnt = fail_cnt + 1;
      end

   a_flag_leds: assert property (@(posedge clk_usb) disable iff (reset)
      change_i |-> (led_armed_i == led_capture_i))
      else begin
         $error("LEDs differ while the frequency change flag is set");
         fail_cnt = fail_cnt + 1;
      end

   a_mon_clear: assert property (@(posedge clk_usb) disable iff (reset)
      ctrl_sh[adc_ctrl_pkg::CTRL_MON_DIS_BIT] |=> !change_i)
      else begin
         $error("change flag still set one cycle after monitor_disable");
         fail_cnt = fail_cnt + 1;
      end

endmodule

bind adc_ctrl_top adc_ctrl_chk u_chk (
   .clk_usb          (clk_usb),
   .reset            (reset),
   .psel_i           (psel_i),
   .penable_i        (penable_i),
   .pwrite_i         (pwrite_i),
   .paddr_i          (paddr_i),
   .pwdata_i         (pwdata_i),
   .prdata_i         (prdata_o),
   .pready_i         (pready_o),
   .pslverr_i        (pslverr_o),
   .capture_active_i (capture_active_i),
   .led_armed_i      (led_armed_o),
   .led_capture_i    (led_capture_o),
   .amp_gain_i       (amp_gain_o),
   .change_i         (extclk_change)
);

// ==== tb_clk_gen.sv ====
module tb_clk_gen #(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 2
) (
   output logic clk_o,
   output logic reset_o
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // synchronous reset, released just after an edge
   initial begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1;
      reset_o = 1'b0;
   end

endmodule

// ==== adc_ctrl_top.sv ====
module adc_ctrl_top #(
   parameter int pTIMER_BITS = 26
) (
   input  logic                            clk_usb,
   input  logic                            reset,
   input  logic                            psel_i,
   input  logic                            penable_i,
   input  logic                            pwrite_i,
   input  logic [adc_ctrl_pkg::ADDR_W-1:0] paddr_i,
   input  logic [adc_ctrl_pkg::DATA_W-1:0] pwdata_i,
   input  logic                            ext_clk_i,
   input  logic                            trigger_i,
   input  logic                            capture_active_i,
   output logic [adc_ctrl_pkg::DATA_W-1:0] prdata_o,
   output logic                            pready_o,
   output logic                            pslverr_o,
   output logic                            led_armed_o,
   output logic                            led_capture_o,
   output logic                            amp_gain_o
);

   logic [adc_ctrl_pkg::LED_SEL_W-1:0] led_select;
   logic                               arm;
   logic                               monitor_disable;
   logic [adc_ctrl_pkg::GAIN_W-1:0]    gain;
   logic [adc_ctrl_pkg::FREQ_W-1:0]    limit;
   logic [adc_ctrl_pkg::FREQ_W-1:0]    freq;
   logic                               extclk_change;
   logic                               ext_level;
   logic                               gate_pulse;   // one cycle per measurement window

   apb_regs u_apb_regs (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .psel_i            (psel_i),
      .penable_i         (penable_i),
      .pwrite_i          (pwrite_i),
      .paddr_i           (paddr_i),
      .pwdata_i          (pwdata_i),
      .prdata_o          (prdata_o),
      .pready_o          (pready_o),
      .pslverr_o         (pslverr_o),
      .freq_i            (freq),
      .extclk_change_i   (extclk_change),
      .trigger_i         (trigger_i),
      .led_select_o      (led_select),
      .arm_o             (arm),
      .monitor_disable_o (monitor_disable),
      .gain_o            (gain),
      .limit_o           (limit)
   );

   board_outputs #(
      .pTIMER_BITS (pTIMER_BITS)
   ) u_board_outputs (
      .clk_usb          (clk_usb),
      .reset            (reset),
      .led_select_i     (led_select),
      .arm_i            (arm),
      .capture_active_i (capture_active_i),
      .extclk_change_i  (extclk_change),
      .ext_level_i      (ext_level),
      .gain_i           (gain),
      .gate_pulse_o     (gate_pulse),
      .led_armed_o      (led_armed_o),
      .led_capture_o    (led_capture_o),
      .amp_gain_o       (amp_gain_o)
   );

   extclk_monitor u_extclk_monitor (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .ext_clk_i         (ext_clk_i),
      .gate_pulse_i      (gate_pulse),
      .monitor_disable_i (monitor_disable),
      .limit_i           (limit),
      .freq_o            (freq),
      .extclk_change_o   (extclk_change),
      .ext_level_o       (ext_level)
   );

endmodule

// ==== extclk_monitor.sv ====
module extclk_monitor (
   input  logic                            clk_usb,
   input  logic                            reset,
   input  logic                            ext_clk_i,
   input  logic                            gate_pulse_i,
   input  logic                            monitor_disable_i,
   input  logic [adc_ctrl_pkg::FREQ_W-1:0] limit_i,
   output logic [adc_ctrl_pkg::FREQ_W-1:0] freq_o,
   output logic                            extclk_change_o,
   output logic                            ext_level_o
);

   logic [2:0]                      ext_sync_q;  // [1:0] synchronizer, [2] edge history
   logic                            ext_rise;
   logic [adc_ctrl_pkg::FREQ_W-1:0] count_q;
   logic [adc_ctrl_pkg::FREQ_W-1:0] freq_q;
   logic [adc_ctrl_pkg::FREQ_W-1:0] delta;
   logic                            moved;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ext_sync_q <= '0;
      end else begin
         ext_sync_q <= {ext_sync_q[1:0], ext_clk_i};
      end
   end

   assign ext_rise    = ext_sync_q[1] & ~ext_sync_q[2];
   assign ext_level_o = ext_sync_q[1];

   // edge counter, restarts at every gate pulse
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         count_q <= '0;
         freq_q  <= '0;
      end else if (gate_pulse_i) begin
         count_q <= ext_rise ? adc_ctrl_pkg::FREQ_W'(1) : '0;
         freq_q  <= count_q;  // close the window
      end else if (ext_rise) begin
         count_q <= count_q + 1'b1;
      end
   end

   // distance between the closing window and the last latched one
   assign delta = (freq_q > count_q) ? (freq_q - count_q) : (count_q - freq_q);
   assign moved = (count_q != '0) && (delta > limit_i);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         extclk_change_o <= 1'b0;
      end else if (monitor_disable_i) begin
         extclk_change_o <= 1'b0;
      end else if (gate_pulse_i && moved) begin
         extclk_change_o <= 1'b1;  // sticky until disabled
      end
   end

   assign freq_o = freq_q;

endmodule

// ==== board_outputs.sv ====
module board_outputs #(
   parameter int pTIMER_BITS = 26
) (
   input  logic                               clk_usb,
   input  logic                               reset,
   input  logic [adc_ctrl_pkg::LED_SEL_W-1:0] led_select_i,
   input  logic                               arm_i,
   input  logic                               capture_active_i,
   input  logic                               extclk_change_i,
   input  logic                               ext_level_i,
   input  logic [adc_ctrl_pkg::GAIN_W-1:0]    gain_i,
   output logic                               gate_pulse_o,
   output logic                               led_armed_o,
   output logic                               led_capture_o,
   output logic                               amp_gain_o
);

   logic [pTIMER_BITS-1:0]          timer_q;
   logic                            gate_bit_q;
   logic                            flash_q;
   logic [adc_ctrl_pkg::GAIN_W:0]   pwm_acc_q;   // msb is the carry out
   logic                            heartbeat;

   assign heartbeat = timer_q[pTIMER_BITS-2];

   // free-running heartbeat timer and gate edge detector
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer_q      <= '0;
         gate_bit_q   <= 1'b0;
         gate_pulse_o <= 1'b0;
      end else begin
         timer_q      <= timer_q + 1'b1;
         gate_bit_q   <= timer_q[pTIMER_BITS-4];
         gate_pulse_o <= timer_q[pTIMER_BITS-4] & ~gate_bit_q;  // rising edge only
      end
   end

   // slow blink, frozen while the timer msb is low
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         flash_q <= 1'b0;
      end else if (timer_q[pTIMER_BITS-1]) begin
         flash_q <= ~timer_q[pTIMER_BITS-3];
      end
   end

   always_comb begin
      if (extclk_change_i) begin
         // a frequency change overrides the selected source
         led_armed_o   = flash_q;
         led_capture_o = flash_q;
      end else begin
         case (led_select_i)
            adc_ctrl_pkg::LED_TIMER: begin
               led_armed_o   = heartbeat;
               led_capture_o = heartbeat;
            end
            adc_ctrl_pkg::LED_EXTCLK: begin
               led_armed_o   = ext_level_i;
               led_capture_o = gate_pulse_o;
            end
            adc_ctrl_pkg::LED_FLAG: begin
               led_armed_o   = flash_q;
               led_capture_o = extclk_change_i;
            end
            default: begin  // LED_NORMAL
               led_armed_o   = arm_i;
               led_capture_o = capture_active_i;
            end
         endcase
      end
   end

   // first-order sigma-delta, carry is high gain_i times per 256 cycles
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         pwm_acc_q <= '0;
      end else begin
         pwm_acc_q <= {1'b0, pwm_acc_q[adc_ctrl_pkg::GAIN_W-1:0]} + {1'b0, gain_i};
      end
   end

   assign amp_gain_o = pwm_acc_q[adc_ctrl_pkg::GAIN_W];

endmodule

// ==== apb_regs.sv ====
module apb_regs (
   input  logic                               clk_usb,
   input  logic                               reset,

   // APB slave
   input  logic                               psel_i,
   input  logic                               penable_i,
   input  logic                               pwrite_i,
   input  logic [adc_ctrl_pkg::ADDR_W-1:0]    paddr_i,
   input  logic [adc_ctrl_pkg::DATA_W-1:0]    pwdata_i,
   output logic [adc_ctrl_pkg::DATA_W-1:0]    prdata_o,
   output logic                               pready_o,
   output logic                               pslverr_o,

   // status sources
   input  logic [adc_ctrl_pkg::FREQ_W-1:0]    freq_i,
   input  logic                               extclk_change_i,
   input  logic                               trigger_i,

   // control levels
   output logic [adc_ctrl_pkg::LED_SEL_W-1:0] led_select_o,
   output logic                               arm_o,
   output logic                               monitor_disable_o,
   output logic [adc_ctrl_pkg::GAIN_W-1:0]    gain_o,
   output logic [adc_ctrl_pkg::FREQ_W-1:0]    limit_o
);

   logic [adc_ctrl_pkg::CTRL_W-1:0] ctrl_q;
   logic [adc_ctrl_pkg::GAIN_W-1:0] gain_q;
   logic [adc_ctrl_pkg::FREQ_W-1:0] limit_q;
   logic [1:0]                      trig_sync_q;  // two-flop synchronizer

   logic access;
   logic mapped;
   logic read_only;
   logic wr_en;

   assign access = psel_i & penable_i;  // access phase, never stalled

   assign read_only = (paddr_i == adc_ctrl_pkg::REG_FREQ) ||
                      (paddr_i == adc_ctrl_pkg::REG_STATUS);

   assign mapped = (paddr_i == adc_ctrl_pkg::REG_CTRL)  ||
                   (paddr_i == adc_ctrl_pkg::REG_GAIN)  ||
                   (paddr_i == adc_ctrl_pkg::REG_LIMIT) ||
                   read_only;

   assign pready_o  = 1'b1;
   assign pslverr_o = access & (~mapped | (pwrite_i & read_only));
   assign wr_en     = access & pwrite_i & ~pslverr_o;  // rejected writes change nothing

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ctrl_q  <= '0;
         gain_q  <= '0;
         limit_q <= '0;
      end else if (wr_en) begin
         case (paddr_i)
            adc_ctrl_pkg::REG_CTRL:  ctrl_q  <= pwdata_i[adc_ctrl_pkg::CTRL_W-1:0];
            adc_ctrl_pkg::REG_GAIN:  gain_q  <= pwdata_i[adc_ctrl_pkg::GAIN_W-1:0];
            adc_ctrl_pkg::REG_LIMIT: limit_q <= pwdata_i[adc_ctrl_pkg::FREQ_W-1:0];
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         trig_sync_q <= '0;
      end else begin
         trig_sync_q <= {trig_sync_q[0], trigger_i};
      end
   end

   // read mux, unused bits read as zero
   always_comb begin
      prdata_o = '0;
      case (paddr_i)
         adc_ctrl_pkg::REG_CTRL:  prdata_o[adc_ctrl_pkg::CTRL_W-1:0] = ctrl_q;
         adc_ctrl_pkg::REG_GAIN:  prdata_o[adc_ctrl_pkg::GAIN_W-1:0] = gain_q;
         adc_ctrl_pkg::REG_LIMIT: prdata_o[adc_ctrl_pkg::FREQ_W-1:0] = limit_q;
         adc_ctrl_pkg::REG_FREQ:  prdata_o[adc_ctrl_pkg::FREQ_W-1:0] = freq_i;
         adc_ctrl_pkg::REG_STATUS: begin
            prdata_o[adc_ctrl_pkg::STAT_CHANGE_BIT] = extclk_change_i;
            prdata_o[adc_ctrl_pkg::STAT_TRIG_BIT]   = trig_sync_q[1];
         end
         default: ;
      endcase
   end

   assign led_select_o      = ctrl_q[adc_ctrl_pkg::CTRL_LED_LSB +: adc_ctrl_pkg::LED_SEL_W];
   assign monitor_disable_o = ctrl_q[adc_ctrl_pkg::CTRL_MON_DIS_BIT];
   assign arm_o             = ctrl_q[adc_ctrl_pkg::CTRL_ARM_BIT];
   assign gain_o            = gain_q;
   assign limit_o           = limit_q;

endmodule

// ==== adc_ctrl_pkg.sv ====
package adc_ctrl_pkg;

   // bus and datapath widths
   localparam int ADDR_W    = 8;
   localparam int DATA_W    = 32;
   localparam int FREQ_W    = 32;
   localparam int GAIN_W    = 8;
   localparam int CTRL_W    = 4;   // implemented bits of REG_CTRL
   localparam int LED_SEL_W = 2;

   // register map
   localparam logic [ADDR_W-1:0] REG_CTRL   = 8'h00;
   localparam logic [ADDR_W-1:0] REG_GAIN   = 8'h04;
   localparam logic [ADDR_W-1:0] REG_LIMIT  = 8'h08;
   localparam logic [ADDR_W-1:0] REG_FREQ   = 8'h0C;  // read only
   localparam logic [ADDR_W-1:0] REG_STATUS = 8'h10;  // read only

   // REG_CTRL fields
   localparam int CTRL_LED_LSB     = 0;
   localparam int CTRL_MON_DIS_BIT = 2;
   localparam int CTRL_ARM_BIT     = 3;

   // REG_STATUS fields
   localparam int STAT_CHANGE_BIT = 0;
   localparam int STAT_TRIG_BIT   = 1;

   // LED source selection
   localparam logic [LED_SEL_W-1:0] LED_NORMAL = 2'b00;
   localparam logic [LED_SEL_W-1:0] LED_TIMER  = 2'b01;
   localparam logic [LED_SEL_W-1:0] LED_EXTCLK = 2'b10;
   localparam logic [LED_SEL_W-1:0] LED_FLAG   = 2'b11;

endpackage
